//--- video_top.f
logic/video_cfg_pkg.sv
logic/video_cmd_pkg.sv
logic/pixel_tick_gen.sv
logic/video_cmd_decoder.sv
logic/frame_writer.sv
logic/frame_buffer.sv
logic/vga_timing.sv
logic/pixel_scanout.sv
logic/video_top.sv
tests/video_tb.sv

//--- Makefile
# Verilator build and run of the video subsystem testbench

VERILATOR ?= verilator
TOP       ?= video_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FLIST     ?= video_top.f
VFLAGS    ?= --assert
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard logic/*.sv tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/video_tb.sv
module video_tb;

  import video_cfg_pkg::*;
  import video_cmd_pkg::*;

  localparam int H_ACTIVE    = 16;
  localparam int H_FRONT     = 2;
  localparam int H_SYNC      = 3;
  localparam int H_BACK      = 3;
  localparam int V_ACTIVE    = 8;
  localparam int V_FRONT     = 1;
  localparam int V_SYNC      = 2;
  localparam int V_BACK      = 1;
  localparam int PIX_DIV     = 4;
  localparam int LOCK_CYCLES = 20;
  localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // ticks per line
  localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // lines per frame
  localparam int FRAME_TICKS = H_TOTAL * V_TOTAL;

  logic        sys_clk;
  logic        rst_n;
  logic        cmd_stb;
  logic [31:0] cmd_word;
  logic        busy;
  logic        err;
  logic        ready;
  logic        pxl_stb;
  vga_sync_t   sync;
  pixel_rgb_t  rgb;

  pixel_rgb_t model_frame [V_ACTIVE][H_ACTIVE];  // expected colour per pixel
  pixel_rgb_t cap_frame [V_ACTIVE][H_ACTIVE];    // last captured frame
  int         model_x;                           // cursor of the model
  int         model_y;
  int         n_checks;
  int         n_errors;
  integer     seed;

  video_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .PIX_DIV(PIX_DIV), .LOCK_CYCLES(LOCK_CYCLES)
  ) dut_i (
    .sys_clk_i(sys_clk), .rst_n_i(rst_n), .cmd_stb_i(cmd_stb), .cmd_word_i(cmd_word),
    .busy_o(busy), .err_o(err), .ready_o(ready), .pxl_stb_o(pxl_stb),
    .sync_o(sync), .rgb_o(rgb)
  );

  always #4 sys_clk = ~sys_clk;  // 8 unit period

  task automatic check_rgb(string name, pixel_rgb_t got, pixel_rgb_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sync(string name, vga_sync_t got, vga_sync_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    n_errors++;
    $display("timeout: %s", what);
  endtask

  // sample and drive point, just after the edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  // stop on the next cycle whose following edge updates the outputs
  task automatic next_tick(output bit ok);
    int guard;
    guard = 0;
    do begin
      next_cycle();
      guard++;
    end while (pxl_stb !== 1'b1 && guard < 2 * PIX_DIV);
    ok = (pxl_stb === 1'b1);
    if (!ok) report_timeout("pixel strobe stopped");
  endtask

  function automatic pixel_rgb_t rand_colour();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  // word layout msb first: op, x, y, colour
  task automatic send_cmd(logic [3:0] op, int x, int y, pixel_rgb_t colour, logic exp_err);
    cmd_word = {op, 8'(x), 8'(y), colour};
    cmd_stb  = 1'b1;
    next_cycle();
    check_bit("err_o", err, exp_err);  // pulse lands one cycle after the strobe
    cmd_stb  = 1'b0;
  endtask

  task automatic model_write(pixel_rgb_t colour);
    model_frame[model_y][model_x] = colour;
    if (model_x == H_ACTIVE - 1) begin
      model_x = 0;
      model_y = (model_y == V_ACTIVE - 1) ? 0 : model_y + 1;  // raster wrap
    end else begin
      model_x++;
    end
  endtask

  task automatic model_fill(pixel_rgb_t colour);
    foreach (model_frame[y, x]) model_frame[y][x] = colour;  // cursor untouched
  endtask

  task automatic wait_vsync_fall(output bit ok);
    int guard;
    bit prev;
    bit t_ok;
    guard = 0;
    prev  = 1'b0;  // no false edge on the first sample
    ok    = 1'b0;
    while (!ok && guard < 2 * FRAME_TICKS) begin
      next_tick(t_ok);
      if (!t_ok) return;
      guard++;
      if (prev && !sync.vsync) ok = 1'b1;
      prev = sync.vsync;
    end
    if (!ok) report_timeout("no vsync falling edge");
  endtask

  // one frame from vsync fall to the next, with line and pulse width checks
  task automatic capture_frame();
    int  x;
    int  y;
    int  hs_run;
    int  vs_run;
    int  guard;
    bit  ok;
    bit  prev_de;
    bit  vs_high_seen;
    bit  done;
    x = 0;
    y = 0;
    hs_run = 0;
    vs_run = 1;  // the falling sample itself
    guard = 0;
    prev_de = 1'b0;
    vs_high_seen = 1'b0;
    done = 1'b0;
    wait_vsync_fall(ok);
    if (!ok) return;
    while (!done && guard < 2 * FRAME_TICKS) begin
      next_tick(ok);
      if (!ok) return;
      guard++;
      if (sync.de) begin
        if (x < H_ACTIVE && y < V_ACTIVE) cap_frame[y][x] = rgb;
        x++;
      end else begin
        check_rgb("rgb_o in blanking", rgb, '0);  // black travels with de
        if (prev_de) begin
          check_count("de samples per line", x, H_ACTIVE);
          x = 0;
          y++;
        end
      end
      prev_de = sync.de;
      if (!sync.hsync) begin
        hs_run++;
      end else if (hs_run > 0) begin
        check_count("hsync low ticks", hs_run, H_SYNC);
        hs_run = 0;
      end
      if (!vs_high_seen && !sync.vsync) begin
        vs_run++;
      end else if (!vs_high_seen) begin
        check_count("vsync low ticks", vs_run, V_SYNC * H_TOTAL);  // V_SYNC lines
        vs_high_seen = 1'b1;
      end else if (!sync.vsync) begin
        done = 1'b1;  // next frame starts
      end
    end
    if (!done) report_timeout("frame never ended");
    else check_count("lines per frame", y, V_ACTIVE);
  endtask

  task automatic compare_frame();
    foreach (model_frame[y, x]) begin
      check_rgb($sformatf("rgb_o[%0d][%0d]", y, x), cap_frame[y][x], model_frame[y][x]);
    end
  endtask

  task automatic test_reset_and_ticks();
    vga_sync_t idle;
    int        n;
    int        gap;
    bit        ok;
    idle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
    next_cycle();
    n = 1;
    check_bit("busy_o", busy, 1'b0);
    check_bit("err_o", err, 1'b0);
    check_bit("ready_o", ready, 1'b0);
    check_sync("sync_o", sync, idle);
    check_rgb("rgb_o", rgb, '0);
    while (ready !== 1'b1 && n < LOCK_CYCLES + 50) begin
      next_cycle();
      n++;
    end
    if (ready !== 1'b1) report_timeout("ready_o never rose");
    else check_count("cycles to ready_o", n, LOCK_CYCLES);
    next_tick(ok);
    for (int i = 0; i < 4; i++) begin
      gap = 0;
      do begin
        next_cycle();
        gap++;
      end while (pxl_stb !== 1'b1 && gap < 4 * PIX_DIV);
      check_count("pxl_stb_o spacing", gap, PIX_DIV);
    end
  endtask

  task automatic test_frame_timing();
    capture_frame();  // counts only, contents still unwritten
  endtask

  task automatic test_fill(pixel_rgb_t colour);
    int guard;
    int n;
    send_cmd(OP_FILL, 0, 0, colour, 1'b0);
    guard = 0;
    while (busy !== 1'b1 && guard < 8) begin
      next_cycle();
      guard++;
    end
    if (busy !== 1'b1) begin
      report_timeout("busy_o never rose after FILL");
      return;
    end
    check_count("busy_o delay after strobe", guard + 1, 2);
    n = 0;
    while (busy === 1'b1 && n < H_ACTIVE * V_ACTIVE + 16) begin
      n++;
      next_cycle();
    end
    if (busy === 1'b1) report_timeout("busy_o stuck high");
    else check_count("busy_o high cycles", n, H_ACTIVE * V_ACTIVE);
    model_fill(colour);
    capture_frame();
    compare_frame();
  endtask

  // run of pixels across a line wrap
  task automatic test_pixel_run();
    pixel_rgb_t colour;
    send_cmd(OP_SET_POS, H_ACTIVE - 3, 2, '0, 1'b0);
    model_x = H_ACTIVE - 3;
    model_y = 2;
    for (int i = 0; i < 6; i++) begin
      colour = rand_colour();
      send_cmd(OP_WRITE_PIXEL, 0, 0, colour, 1'b0);  // x y ignored
      model_write(colour);
    end
    capture_frame();
    compare_frame();
  endtask

  task automatic test_bad_cmds();
    pixel_rgb_t colour;
    send_cmd(4'ha, 1, 1, rand_colour(), 1'b1);    // reserved opcode
    send_cmd(OP_SET_POS, H_ACTIVE, 0, '0, 1'b1);  // x off screen
    send_cmd(OP_SET_POS, 0, V_ACTIVE, '0, 1'b1);  // y off screen
    send_cmd(OP_NOP, 5, 5, rand_colour(), 1'b0);  // legal, no effect
    colour = rand_colour();
    send_cmd(OP_WRITE_PIXEL, 0, 0, colour, 1'b0);  // lands at old cursor
    model_write(colour);
    capture_frame();
    compare_frame();
  endtask

  initial begin
    sys_clk  = 1'b0;
    rst_n    = 1'b0;
    cmd_stb  = 1'b0;
    cmd_word = '0;
    model_x  = 0;
    model_y  = 0;
    n_checks = 0;
    n_errors = 0;
    seed     = 32'h26f2_1505;
    repeat (10) next_cycle();
    rst_n = 1'b1;
    test_reset_and_ticks();
    test_frame_timing();
    test_fill(12'h5a3);
    test_pixel_run();
    test_bad_cmds();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- logic/video_top.sv
module video_top #(
  parameter int H_ACTIVE    = 16,  // tiny active area for simulation
  parameter int H_FRONT     = 2,
  parameter int H_SYNC      = 3,
  parameter int H_BACK      = 3,
  parameter int V_ACTIVE    = 8,
  parameter int V_FRONT     = 1,
  parameter int V_SYNC      = 2,
  parameter int V_BACK      = 1,
  parameter int PIX_DIV     = 4,   // sys clocks per pixel
  parameter int LOCK_CYCLES = 20   // delay before ready
) (
  input  logic                      sys_clk_i,
  input  logic                      rst_n_i,
  input  logic                      cmd_stb_i,   // CPU command strobe
  input  logic [31:0]               cmd_word_i,  // CPU command word
  output logic                      busy_o,      // fill running
  output logic                      err_o,       // command rejected
  output logic                      ready_o,     // display running
  output logic                      pxl_stb_o,   // pixel enable
  output video_cfg_pkg::vga_sync_t  sync_o,
  output video_cfg_pkg::pixel_rgb_t rgb_o
);

  import video_cfg_pkg::*;
  import video_cmd_pkg::*;

  logic       dec_vld;     // decoder to writer
  vid_cmd_t   dec_cmd;
  fb_wr_t     fb_wr;       // writer to buffer
  vga_pos_t   scan_pos;    // timing to buffer read
  vga_sync_t  raw_sync;    // timing to scanout
  pixel_rgb_t fb_rd_data;  // buffer to scanout

  pixel_tick_gen #(
    .PIX_DIV(PIX_DIV), .LOCK_CYCLES(LOCK_CYCLES)
  ) tick_i (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
    .pxl_stb_o(pxl_stb_o), .ready_o(ready_o)
  );

  video_cmd_decoder #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) decoder_i (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
    .cmd_stb_i(cmd_stb_i), .cmd_word_i(cmd_word_i),
    .cmd_vld_o(dec_vld), .cmd_o(dec_cmd), .err_o(err_o)
  );

  frame_writer #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) writer_i (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
    .cmd_vld_i(dec_vld), .cmd_i(dec_cmd),
    .wr_o(fb_wr), .busy_o(busy_o)
  );

  frame_buffer #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
  ) buffer_i (
    .sys_clk_i(sys_clk_i), .wr_i(fb_wr),
    .rd_pos_i(scan_pos), .rd_data_o(fb_rd_data)
  );

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) timing_i (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
    .pxl_stb_i(pxl_stb_o), .ready_i(ready_o),
    .pos_o(scan_pos), .sync_o(raw_sync)
  );

  pixel_scanout scanout_i (
    .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i), .pxl_stb_i(pxl_stb_o),
    .sync_i(raw_sync), .rd_data_i(fb_rd_data),
    .sync_o(sync_o), .rgb_o(rgb_o)
  );

endmodule

//--- logic/pixel_scanout.sv
module pixel_scanout (
  input  logic                      sys_clk_i,
  input  logic                      rst_n_i,
  input  logic                      pxl_stb_i,  // pixel enable
  input  video_cfg_pkg::vga_sync_t  sync_i,     // sync of current counters
  input  video_cfg_pkg::pixel_rgb_t rd_data_i,  // buffer data for same position
  output video_cfg_pkg::vga_sync_t  sync_o,     // one pixel late
  output video_cfg_pkg::pixel_rgb_t rgb_o       // aligned with sync_o
);

  import video_cfg_pkg::*;

  localparam pixel_rgb_t BLACK = '0;

  pixel_rgb_t pix_masked;  // data or black in blanking

  assign pix_masked = sync_i.de ? rd_data_i : BLACK;

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      sync_o <= SYNC_IDLE;
      rgb_o  <= BLACK;
    end else if (pxl_stb_i) begin
      sync_o <= sync_i;      // delayed de travels with rgb
      rgb_o  <= pix_masked;  // read data settled a cycle ago
    end
  end

  // buffer read needs a spare cycle between ticks
  a_tick_spacing: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) pxl_stb_i |=> !pxl_stb_i
  );

endmodule

//--- logic/vga_timing.sv
module vga_timing #(
  parameter int H_ACTIVE = 16,  // visible columns
  parameter int H_FRONT  = 2,
  parameter int H_SYNC   = 3,
  parameter int H_BACK   = 3,
  parameter int V_ACTIVE = 8,   // visible lines
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 1
) (
  input  logic                     sys_clk_i,
  input  logic                     rst_n_i,
  input  logic                     pxl_stb_i,  // pixel enable
  input  logic                     ready_i,    // pixel source locked
  output video_cfg_pkg::vga_pos_t  pos_o,      // current counters
  output video_cfg_pkg::vga_sync_t sync_o      // sync for current counters
);

  import video_cfg_pkg::*;

  // region order is active front sync back
  localparam int H_SYNC_BEG = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END = H_SYNC_BEG + H_SYNC;
  localparam int H_TOTAL    = H_SYNC_END + H_BACK;
  localparam int V_SYNC_BEG = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END = V_SYNC_BEG + V_SYNC;
  localparam int V_TOTAL    = V_SYNC_END + V_BACK;

  logic [COORD_W-1:0] h_cnt_q;    // column counter
  logic [COORD_W-1:0] v_cnt_q;    // line counter
  logic               advance;    // step this cycle
  logic               h_last;
  logic               v_last;
  logic               h_act;
  logic               v_act;
  logic               h_sync_on;
  logic               v_sync_on;

  assign advance = pxl_stb_i && ready_i;  // frozen until ready
  assign h_last  = (int'(h_cnt_q) == H_TOTAL - 1);
  assign v_last  = (int'(v_cnt_q) == V_TOTAL - 1);

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (advance) begin
      if (h_last) begin
        h_cnt_q <= '0;
        v_cnt_q <= v_last ? '0 : v_cnt_q + 1'b1;  // next line or new frame
      end else begin
        h_cnt_q <= h_cnt_q + 1'b1;
      end
    end
  end

  assign h_act     = (int'(h_cnt_q) < H_ACTIVE);
  assign v_act     = (int'(v_cnt_q) < V_ACTIVE);
  assign h_sync_on = (int'(h_cnt_q) >= H_SYNC_BEG) && (int'(h_cnt_q) < H_SYNC_END);
  assign v_sync_on = (int'(v_cnt_q) >= V_SYNC_BEG) && (int'(v_cnt_q) < V_SYNC_END);

  assign pos_o = '{x: h_cnt_q, y: v_cnt_q};

  always_comb begin
    if (ready_i) begin
      sync_o.hsync = !h_sync_on;  // active low
      sync_o.vsync = !v_sync_on;
      sync_o.de    = h_act && v_act;
    end else begin
      sync_o = SYNC_IDLE;  // quiet display before lock
    end
  end

  // lock never drops once the raster runs
  a_ready_holds: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) ready_i |=> ready_i
  );

endmodule

//--- logic/frame_buffer.sv
module frame_buffer #(
  parameter int H_ACTIVE = 16,  // visible columns
  parameter int V_ACTIVE = 8    // visible lines
) (
  input  logic                      sys_clk_i,
  input  video_cmd_pkg::fb_wr_t     wr_i,      // write side from the writer
  input  video_cfg_pkg::vga_pos_t   rd_pos_i,  // read side from timing
  output video_cfg_pkg::pixel_rgb_t rd_data_o  // one cycle after rd_pos_i
);

  import video_cfg_pkg::*;

  localparam int DEPTH  = H_ACTIVE * V_ACTIVE;
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pixel_rgb_t        mem [DEPTH];  // row major frame
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  function automatic logic [ADDR_W-1:0] pos_to_addr(vga_pos_t pos);
    return ADDR_W'(int'(pos.y) * H_ACTIVE + int'(pos.x));  // y * width + x
  endfunction

  assign wr_addr = pos_to_addr(wr_i.pos);
  assign rd_addr = pos_to_addr(rd_pos_i);  // blanking positions alias and get masked later

  always_ff @(posedge sys_clk_i) begin
    if (wr_i.we) begin
      mem[wr_addr] <= wr_i.colour;
    end
    rd_data_o <= mem[rd_addr];  // registered read
  end

  // the writer only ever targets visible pixels
  a_wr_in_range: assert property (
    @(posedge sys_clk_i) wr_i.we |->
      (int'(wr_i.pos.x) < H_ACTIVE) && (int'(wr_i.pos.y) < V_ACTIVE)
  );

endmodule

//--- logic/frame_writer.sv
module frame_writer #(
  parameter int H_ACTIVE = 16,  // visible columns
  parameter int V_ACTIVE = 8    // visible lines
) (
  input  logic                    sys_clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_vld_i,  // decoded command pulse
  input  video_cmd_pkg::vid_cmd_t cmd_i,      // decoded command
  output video_cmd_pkg::fb_wr_t   wr_o,       // buffer write port
  output logic                    busy_o      // fill in progress
);

  import video_cfg_pkg::*;
  import video_cmd_pkg::*;

  typedef enum logic {
    IDLE,  // taking commands
    FILL   // sweeping the frame
  } fill_state_e;

  localparam logic [COORD_W-1:0] X_LAST = COORD_W'(H_ACTIVE - 1);
  localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(V_ACTIVE - 1);

  fill_state_e        state_q;
  logic [COORD_W-1:0] cur_x_q;        // cursor column
  logic [COORD_W-1:0] cur_y_q;        // cursor line
  logic [COORD_W-1:0] fill_x_q;       // sweep column
  logic [COORD_W-1:0] fill_y_q;       // sweep line
  pixel_rgb_t         fill_colour_q;  // fill colour held for the sweep
  logic               pix_we_q;       // single pixel write pending
  vga_pos_t           pix_pos_q;
  pixel_rgb_t         pix_colour_q;
  logic               do_set;
  logic               do_pixel;
  logic               do_fill;

  assign do_set   = cmd_vld_i && (cmd_i.op == OP_SET_POS);
  assign do_pixel = cmd_vld_i && (cmd_i.op == OP_WRITE_PIXEL);
  assign do_fill  = cmd_vld_i && (cmd_i.op == OP_FILL);

  // cursor and its raster step
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      cur_x_q <= '0;
      cur_y_q <= '0;
    end else if (do_set) begin
      cur_x_q <= COORD_W'(cmd_i.x);  // range checked by decoder
      cur_y_q <= COORD_W'(cmd_i.y);
    end else if (do_pixel) begin
      if (cur_x_q == X_LAST) begin
        cur_x_q <= '0;
        cur_y_q <= (cur_y_q == Y_LAST) ? '0 : cur_y_q + 1'b1;  // wrap to top
      end else begin
        cur_x_q <= cur_x_q + 1'b1;
      end
    end
  end

  // fill sweep one pixel per cycle
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      fill_x_q <= '0;
      fill_y_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (do_fill) begin
            state_q  <= FILL;
            fill_x_q <= '0;
            fill_y_q <= '0;
          end
        end
        FILL: begin
          if (fill_x_q == X_LAST) begin
            fill_x_q <= '0;
            if (fill_y_q == Y_LAST) begin
              state_q <= IDLE;  // last pixel written this cycle
            end else begin
              fill_y_q <= fill_y_q + 1'b1;
            end
          end else begin
            fill_x_q <= fill_x_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      pix_we_q <= 1'b0;
    end else begin
      pix_we_q <= do_pixel;
    end
  end

  // payload for pixel and fill
  always_ff @(posedge sys_clk_i) begin
    if (do_pixel) begin
      pix_pos_q    <= '{x: cur_x_q, y: cur_y_q};  // cursor before the step
      pix_colour_q <= cmd_i.colour;
    end
    if (do_fill) begin
      fill_colour_q <= cmd_i.colour;
    end
  end

  always_comb begin
    if (state_q == FILL) begin
      wr_o = '{we: 1'b1, pos: '{x: fill_x_q, y: fill_y_q}, colour: fill_colour_q};
    end else begin
      wr_o = '{we: pix_we_q, pos: pix_pos_q, colour: pix_colour_q};
    end
  end

  assign busy_o = (state_q == FILL);

  // CPU must hold off while a fill runs
  a_no_cmd_when_busy: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) cmd_vld_i |-> !busy_o
  );

endmodule

//--- logic/video_cmd_decoder.sv
module video_cmd_decoder #(
  parameter int H_ACTIVE = 16,  // visible columns
  parameter int V_ACTIVE = 8    // visible lines
) (
  input  logic                    sys_clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_stb_i,   // word present this cycle
  input  logic [31:0]             cmd_word_i,  // raw command word
  output logic                    cmd_vld_o,   // decoded command pulse
  output video_cmd_pkg::vid_cmd_t cmd_o,       // decoded command
  output logic                    err_o        // rejected command pulse
);

  import video_cmd_pkg::*;

  vid_cmd_t raw_cmd;  // word split into fields
  logic     op_ok;    // opcode is known
  logic     pos_ok;   // SET_POS target inside active area
  logic     cmd_ok;   // whole command legal

  // field unpack
  always_comb begin
    raw_cmd.op     = vid_op_e'(cmd_word_i[31:28]);
    raw_cmd.x      = cmd_word_i[27:20];
    raw_cmd.y      = cmd_word_i[19:12];
    raw_cmd.colour = cmd_word_i[11:0];
  end

  always_comb begin
    case (raw_cmd.op)
      OP_NOP, OP_SET_POS, OP_WRITE_PIXEL, OP_FILL: op_ok = 1'b1;
      default:                                     op_ok = 1'b0;  // reserved codes
    endcase
  end

  assign pos_ok = (int'(raw_cmd.x) < H_ACTIVE) && (int'(raw_cmd.y) < V_ACTIVE);
  assign cmd_ok = op_ok && ((raw_cmd.op != OP_SET_POS) || pos_ok);  // range only for SET_POS

  // control pulses
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      cmd_vld_o <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      cmd_vld_o <= cmd_stb_i && cmd_ok;   // good command goes on
      err_o     <= cmd_stb_i && !cmd_ok;  // bad one is dropped
    end
  end

  // payload register
  always_ff @(posedge sys_clk_i) begin
    if (cmd_stb_i) begin
      cmd_o <= raw_cmd;
    end
  end

endmodule

//--- logic/pixel_tick_gen.sv
module pixel_tick_gen #(
  parameter int PIX_DIV     = 4,   // sys clocks per pixel
  parameter int LOCK_CYCLES = 20   // stand in for clock manager lock time
) (
  input  logic sys_clk_i,
  input  logic rst_n_i,
  output logic pxl_stb_o,  // one cycle pixel enable
  output logic ready_o     // high once lock delay is over
);

  localparam int DIV_W  = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
  localparam int LOCK_W = $clog2(LOCK_CYCLES + 1);

  logic [DIV_W-1:0]  div_cnt_q;   // modulo PIX_DIV phase
  logic [LOCK_W-1:0] lock_cnt_q;  // saturating lock counter
  logic              stb_q;

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
      stb_q     <= 1'b0;
    end else begin
      stb_q <= (div_cnt_q == DIV_W'(PIX_DIV - 1));  // strobe at end of phase
      if (div_cnt_q == DIV_W'(PIX_DIV - 1)) begin
        div_cnt_q <= '0;  // wrap
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      lock_cnt_q <= '0;
    end else if (lock_cnt_q != LOCK_W'(LOCK_CYCLES)) begin
      lock_cnt_q <= lock_cnt_q + 1'b1;  // stops at LOCK_CYCLES
    end
  end

  assign pxl_stb_o = stb_q;
  assign ready_o   = (lock_cnt_q == LOCK_W'(LOCK_CYCLES));  // "locked"

endmodule

//--- logic/video_cmd_pkg.sv
package video_cmd_pkg;

  import video_cfg_pkg::*;

  // opcode field of a command word
  typedef enum logic [3:0] {
    OP_NOP         = 4'h0,  // accepted and ignored
    OP_SET_POS     = 4'h1,  // load cursor
    OP_WRITE_PIXEL = 4'h2,  // write at cursor then step
    OP_FILL        = 4'h3   // paint whole frame
  } vid_op_e;

  // word layout msb first is op x y colour
  typedef struct packed {
    vid_op_e    op;      // opcode
    logic [7:0] x;       // column argument
    logic [7:0] y;       // line argument
    pixel_rgb_t colour;  // colour argument
  } vid_cmd_t;

  // single write into the frame buffer
  typedef struct packed {
    logic       we;      // write enable
    vga_pos_t   pos;     // target pixel
    pixel_rgb_t colour;  // data
  } fb_wr_t;

endpackage

//--- logic/video_cfg_pkg.sv
package video_cfg_pkg;

  localparam int COORD_W = 10;  // width of x and y counters

  // one 12 bit colour per pixel
  typedef struct packed {
    logic [3:0] r;  // red
    logic [3:0] g;  // green
    logic [3:0] b;  // blue
  } pixel_rgb_t;

  // screen position in pixels
  typedef struct packed {
    logic [COORD_W-1:0] x;  // column
    logic [COORD_W-1:0] y;  // line
  } vga_pos_t;

  // sync pulses are active low
  typedef struct packed {
    logic hsync;  // horizontal sync
    logic vsync;  // vertical sync
    logic de;     // data enable in active area
  } vga_sync_t;

  // idle level of the sync bundle
  localparam vga_sync_t SYNC_IDLE = '{
    hsync: 1'b1,
    vsync: 1'b1,
    de:    1'b0
  };

endpackage
